// File: board_pkg.sv
// Board management package
// Shared types and default constants for the bring-up logic that runs
// on the free-running configuration clock: reset sequencing, switch
// debouncing and input synchronization.

package board_pkg;

    // Board switches
    localparam int SW_WIDTH = 4;

    typedef logic [SW_WIDTH-1:0] sw_t;

    // Reset sequencer states
    typedef enum logic [1:0] {
        SEQ_HOLD_ALL = 2'd0,
        SEQ_HOLD_SYS = 2'd1,
        SEQ_RUN      = 2'd2
    } seq_state_e;

    // One sequencer period is 2**width cycles
    localparam int DEF_RESET_TIMER_WIDTH = 10;

    // Synchronizer depth
    localparam int DEF_SYNC_STAGES = 2;

    // Samples that must agree before a switch output moves
    localparam int DEF_DEBOUNCE_DEPTH = 4;

    // Clock cycles between debounce samples
    localparam int DEF_DEBOUNCE_RATE = 156000;

endpackage

// File: signal_sync.sv
// Input synchronizer
// Moves an asynchronous input of any packed type into the cfgmclk_int
// domain through a chain of STAGES flops.

`timescale 1ns/1ns

module signal_sync #(
    parameter type T      = logic,
    parameter int  STAGES = 2
) (
    input  logic cfgmclk_int,
    input  logic gt_tx_reset,
    input  T     in,
    output T     out
);

    T sync_q [STAGES];

    always_ff @(posedge cfgmclk_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            sync_q <= '{default: '0};
        end else begin
            sync_q[0] <= in;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign out = sync_q[STAGES-1];

    // A single flop gives no metastability margin
    a_min_stages: assert property (@(posedge cfgmclk_int) STAGES >= 2)
        else $error("signal_sync needs at least 2 stages, got %0d", STAGES);

endmodule

// File: switch_debounce.sv
// Switch debouncer
// Samples the synchronized switches once every RATE cycles and keeps a
// DEPTH-deep history per switch. An output bit follows its switch only
// when the whole history agrees. Everything is held cleared while the
// system reset is asserted.

`timescale 1ns/1ns

module switch_debounce
    import board_pkg::*;
#(
    parameter int DEPTH = DEF_DEBOUNCE_DEPTH,
    parameter int RATE  = DEF_DEBOUNCE_RATE
) (
    input  logic cfgmclk_int,
    input  logic gt_tx_reset,
    input  logic hold,
    input  sw_t  sw,
    output sw_t  sw_debounced
);

    localparam int CNT_WIDTH = (RATE > 1) ? $clog2(RATE) : 1;
    localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(RATE - 1);

    logic [CNT_WIDTH-1:0] rate_cnt_q;
    logic                 tick;

    logic [SW_WIDTH-1:0][DEPTH-1:0] hist_q;
    logic [SW_WIDTH-1:0][DEPTH-1:0] hist_next;

    // Sample strobe, first one RATE cycles after hold drops
    assign tick = (rate_cnt_q == CNT_LAST);

    always_ff @(posedge cfgmclk_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            rate_cnt_q <= '0;
        end else if (hold) begin
            rate_cnt_q <= '0;
        end else if (tick) begin
            rate_cnt_q <= '0;
        end else begin
            rate_cnt_q <= rate_cnt_q + 1'b1;
        end
    end

    // History including the sample taken at this tick
    always_comb begin
        for (int i = 0; i < SW_WIDTH; i++) begin
            hist_next[i] = {hist_q[i][DEPTH-2:0], sw[i]};
        end
    end

    always_ff @(posedge cfgmclk_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            hist_q       <= '0;
            sw_debounced <= '0;
        end else if (hold) begin
            hist_q       <= '0;
            sw_debounced <= '0;
        end else if (tick) begin
            hist_q <= hist_next;
            for (int i = 0; i < SW_WIDTH; i++) begin
                if (&hist_next[i]) begin
                    sw_debounced[i] <= 1'b1;
                end else if (~|hist_next[i]) begin
                    sw_debounced[i] <= 1'b0;
                end
            end
        end
    end

    // Outputs only move on a sample, or when hold clears them
    a_change_on_tick: assert property (
        @(posedge cfgmclk_int) disable iff (gt_tx_reset)
        $changed(sw_debounced) |-> ($past(tick) || $past(hold))
    ) else $error("sw_debounced changed outside a debounce tick");

endmodule

// File: reset_sequencer.sv
// Board reset sequencer
// Holds the QSFP reference-clock reset and the system reset after
// power-up. One full timer period after the button is released the
// reference-clock reset drops, and one period later the system reset
// drops. Pressing the button restarts the whole sequence.

`timescale 1ns/1ns

module reset_sequencer
    import board_pkg::*;
#(
    parameter int TIMER_WIDTH = DEF_RESET_TIMER_WIDTH
) (
    input  logic cfgmclk_int,
    input  logic gt_tx_reset,
    input  logic button_n,
    output logic qsfp_refclk_reset,
    output logic sys_reset
);

    seq_state_e             state_q;
    logic [TIMER_WIDTH-1:0] timer_q;
    logic                   timer_done;

    assign timer_done = &timer_q;

    always_ff @(posedge cfgmclk_int or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state_q           <= SEQ_HOLD_ALL;
            timer_q           <= '0;
            qsfp_refclk_reset <= 1'b1;
            sys_reset         <= 1'b1;
        end else if (!button_n) begin
            // Button held, restart from the top
            state_q           <= SEQ_HOLD_ALL;
            timer_q           <= '0;
            qsfp_refclk_reset <= 1'b1;
            sys_reset         <= 1'b1;
        end else if (!timer_done) begin
            timer_q <= timer_q + 1'b1;
        end else begin
            case (state_q)
                SEQ_HOLD_ALL: begin
                    // Clock generator comes up first
                    qsfp_refclk_reset <= 1'b0;
                    timer_q           <= '0;
                    state_q           <= SEQ_HOLD_SYS;
                end
                SEQ_HOLD_SYS: begin
                    sys_reset <= 1'b0;
                    state_q   <= SEQ_RUN;
                end
                SEQ_RUN: begin
                    // Timer parks at all ones
                    state_q <= SEQ_RUN;
                end
                default: begin
                    state_q           <= SEQ_HOLD_ALL;
                    timer_q           <= '0;
                    qsfp_refclk_reset <= 1'b1;
                    sys_reset         <= 1'b1;
                end
            endcase
        end
    end

    // The system side must never run on a reference clock still in reset
    a_sys_after_refclk: assert property (
        @(posedge cfgmclk_int) disable iff (gt_tx_reset)
        qsfp_refclk_reset |-> sys_reset
    ) else $error("sys_reset released while qsfp_refclk_reset is high");

    a_refclk_state: assert property (
        @(posedge cfgmclk_int) disable iff (gt_tx_reset)
        !qsfp_refclk_reset |-> (state_q != SEQ_HOLD_ALL)
    ) else $error("qsfp_refclk_reset low in SEQ_HOLD_ALL");

endmodule

// File: board_mgmt_top.sv
// Board management top level
// Bring-up logic on the configuration clock. Synchronizes the reset
// button, the switches and the UART receive line, orders the QSFP
// reference-clock and system resets, and debounces the switches once
// the system is out of reset.

`timescale 1ns/1ns

module board_mgmt_top
    import board_pkg::*;
#(
    parameter int RESET_TIMER_WIDTH = DEF_RESET_TIMER_WIDTH,
    parameter int SYNC_STAGES       = DEF_SYNC_STAGES,
    parameter int DEBOUNCE_DEPTH    = DEF_DEBOUNCE_DEPTH,
    parameter int DEBOUNCE_RATE     = DEF_DEBOUNCE_RATE
) (
    input  logic cfgmclk_int,
    input  logic gt_tx_reset,
    input  logic reset_btn_n,
    input  sw_t  sw,
    input  logic uart_txd,
    output logic qsfp_refclk_reset,
    output logic sys_reset,
    output sw_t  sw_debounced,
    output logic uart_txd_sync
);

    logic button_n_sync;
    sw_t  sw_sync;

    // Push button, active low
    signal_sync #(
        .T      (logic),
        .STAGES (SYNC_STAGES)
    ) button_sync_i (
        .cfgmclk_int (cfgmclk_int),
        .gt_tx_reset (gt_tx_reset),
        .in          (reset_btn_n),
        .out         (button_n_sync)
    );

    signal_sync #(
        .T      (sw_t),
        .STAGES (SYNC_STAGES)
    ) sw_sync_i (
        .cfgmclk_int (cfgmclk_int),
        .gt_tx_reset (gt_tx_reset),
        .in          (sw),
        .out         (sw_sync)
    );

    // UART receive line into the local domain
    signal_sync #(
        .T      (logic),
        .STAGES (SYNC_STAGES)
    ) uart_sync_i (
        .cfgmclk_int (cfgmclk_int),
        .gt_tx_reset (gt_tx_reset),
        .in          (uart_txd),
        .out         (uart_txd_sync)
    );

    reset_sequencer #(
        .TIMER_WIDTH (RESET_TIMER_WIDTH)
    ) reset_sequencer_i (
        .cfgmclk_int       (cfgmclk_int),
        .gt_tx_reset       (gt_tx_reset),
        .button_n          (button_n_sync),
        .qsfp_refclk_reset (qsfp_refclk_reset),
        .sys_reset         (sys_reset)
    );

    // Debouncer stays idle until the system is released
    switch_debounce #(
        .DEPTH (DEBOUNCE_DEPTH),
        .RATE  (DEBOUNCE_RATE)
    ) switch_debounce_i (
        .cfgmclk_int  (cfgmclk_int),
        .gt_tx_reset  (gt_tx_reset),
        .hold         (sys_reset),
        .sw           (sw_sync),
        .sw_debounced (sw_debounced)
    );

endmodule

// File: board_mgmt_tb_tasks.svh
// Board management directed tests
// Tasks that drive the DUT ports and check reset sequencing,
// button restart, debouncing and UART synchronization.

`ifndef BOARD_MGMT_TB_TASKS_SVH
`define BOARD_MGMT_TB_TASKS_SVH

// Just after the next rising edge, outputs are settled
task automatic next_cycle();
    @(posedge cfgmclk_int);
    #DRIVE_DELAY;
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("** Error: %s expected 0x%0h, got 0x%0h at %0t ns",
                 name, expected, actual, $time);
        error_count++;
    end
endtask

task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    error_count++;
endtask

task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
        tests_passed++;
        $display("Test %s passed", name);
    end else begin
        tests_failed++;
        $display("Test %s failed with %0d errors", name, error_count - errors_before);
    end
endtask

task automatic apply_reset();
    gt_tx_reset = 1'b1;
    repeat (2) next_cycle();
    gt_tx_reset = 1'b0;
endtask

task automatic check_reset_outputs();
    check_value("qsfp_refclk_reset", 1, 32'(qsfp_refclk_reset));
    check_value("sys_reset", 1, 32'(sys_reset));
    check_value("sw_debounced", 0, 32'(sw_debounced));
endtask

// Refclk release window, then sys_reset one full period later
task automatic measure_sequence();
    int cycles;
    cycles = 0;
    while (qsfp_refclk_reset === 1'b1 && cycles <= REFCLK_MAX) begin
        next_cycle();
        cycles++;
        check_value("sys_reset", 1, 32'(sys_reset));
    end
    if (qsfp_refclk_reset === 1'b1) begin
        report_problem($sformatf("qsfp_refclk_reset still high after %0d cycles", cycles));
    end else if (cycles < SEQ_PERIOD || cycles > REFCLK_MAX) begin
        report_problem($sformatf("qsfp_refclk_reset fell after %0d cycles, window %0d to %0d",
                                 cycles, SEQ_PERIOD, REFCLK_MAX));
    end
    cycles = 0;
    while (sys_reset === 1'b1 && cycles <= SEQ_PERIOD) begin
        next_cycle();
        cycles++;
        check_value("qsfp_refclk_reset", 0, 32'(qsfp_refclk_reset));
    end
    if (cycles != SEQ_PERIOD) begin
        report_problem($sformatf("sys_reset fell %0d cycles after refclk release, expected %0d",
                                 cycles, SEQ_PERIOD));
    end
endtask

task automatic test_reset_state();
    int errors_before;
    errors_before = error_count;
    gt_tx_reset = 1'b1;
    repeat (2) begin
        next_cycle();
        check_reset_outputs();
    end
    gt_tx_reset = 1'b0;
    next_cycle();
    check_reset_outputs();
    finish_test("reset_state", errors_before);
endtask

task automatic test_sequence();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    measure_sequence();
    finish_test("sequence", errors_before);
endtask

task automatic test_button_restart();
    int errors_before;
    int cycles;
    errors_before = error_count;
    check_value("sys_reset", 0, 32'(sys_reset));
    reset_btn_n = 1'b0;
    cycles = 0;
    while (!(qsfp_refclk_reset === 1'b1 && sys_reset === 1'b1)
           && cycles <= PRESS_MAX) begin
        next_cycle();
        cycles++;
    end
    if (cycles > PRESS_MAX) begin
        report_problem($sformatf("resets not raised within %0d cycles of the press", PRESS_MAX));
    end
    // Both resets stay up for as long as the button is held
    repeat (HOLD_CYCLES) begin
        next_cycle();
        check_value("qsfp_refclk_reset", 1, 32'(qsfp_refclk_reset));
        check_value("sys_reset", 1, 32'(sys_reset));
    end
    reset_btn_n = 1'b1;
    measure_sequence();
    finish_test("button_restart", errors_before);
endtask

task automatic test_debounce_accept();
    int   errors_before;
    int   cycles;
    sw_t  target;
    errors_before = error_count;
    check_value("sys_reset", 0, 32'(sys_reset));
    // Nonzero flip mask so the output has to move
    target = sw ^ sw_t'(($urandom % ((1 << SW_WIDTH) - 1)) + 1);
    sw = target;
    cycles = 0;
    while (sw_debounced !== target && cycles < DEB_LATENCY) begin
        next_cycle();
        cycles++;
    end
    check_value("sw_debounced", 32'(target), 32'(sw_debounced));
    finish_test("debounce_accept", errors_before);
endtask

task automatic test_glitch_reject();
    int   errors_before;
    int   pulse_len;
    sw_t  steady;
    bit   moved;
    errors_before = error_count;
    steady = sw;
    pulse_len = int'($urandom % GLITCH_MAX) + 1;
    moved = 1'b0;
    sw = ~steady;
    repeat (pulse_len + DEB_LATENCY) begin
        next_cycle();
        if (!moved && sw_debounced !== steady) begin
            check_value("sw_debounced", 32'(steady), 32'(sw_debounced));
            moved = 1'b1;
        end
        pulse_len--;
        if (pulse_len == 0) begin
            sw = steady;
        end
    end
    finish_test("glitch_reject", errors_before);
endtask

task automatic test_uart_sync();
    int   errors_before;
    bit   sent[$];
    bit   line_bit;
    errors_before = error_count;
    repeat (UART_BITS + SYNC_STAGES) begin
        next_cycle();
        if (sent.size() >= SYNC_STAGES) begin
            check_value("uart_txd_sync", 32'(sent[sent.size() - SYNC_STAGES]),
                        32'(uart_txd_sync));
        end
        line_bit = 1'($urandom);
        uart_txd = line_bit;
        sent.push_back(line_bit);
    end
    finish_test("uart_sync", errors_before);
endtask

`endif

// File: board_mgmt_tb.sv
// Board management testbench
// Drives the bring-up top level through reset, the reset sequence,
// a button restart, switch debouncing and UART line synchronization.
// Uses short timer and debounce settings to keep the run brief.

`timescale 1ns/1ns

module board_mgmt_tb
    import board_pkg::*;
();

    localparam int TIMER_WIDTH = 4;
    localparam int SYNC_STAGES = 2;
    localparam int DEB_DEPTH   = 4;
    localparam int DEB_RATE    = 4;

    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DELAY = 5;

    // Expected timing, from the sequencing and debounce rules
    localparam int SEQ_PERIOD  = 2 ** TIMER_WIDTH;
    localparam int REFCLK_MAX  = SEQ_PERIOD + SYNC_STAGES + 2;
    localparam int PRESS_MAX   = SYNC_STAGES + 1;
    localparam int HOLD_CYCLES = 10;
    localparam int DEB_LATENCY = (DEB_DEPTH + 1) * DEB_RATE + SYNC_STAGES + 1;
    localparam int GLITCH_MAX  = (DEB_DEPTH - 1) * DEB_RATE - 1;
    localparam int UART_BITS   = 32;

    // Worst case of every test added up
    localparam int TEST_CYCLES = 3
                               + (2 + (REFCLK_MAX + 1) + (SEQ_PERIOD + 1))
                               + ((PRESS_MAX + 1) + HOLD_CYCLES
                                  + (REFCLK_MAX + 1) + (SEQ_PERIOD + 1))
                               + DEB_LATENCY
                               + (GLITCH_MAX + DEB_LATENCY)
                               + (UART_BITS + SYNC_STAGES);
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 2;

    logic cfgmclk_int;
    logic gt_tx_reset;
    logic reset_btn_n;
    sw_t  sw;
    logic uart_txd;
    logic qsfp_refclk_reset;
    logic sys_reset;
    sw_t  sw_debounced;
    logic uart_txd_sync;

    int          error_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count  = 0;

    board_mgmt_top #(
        .RESET_TIMER_WIDTH (TIMER_WIDTH),
        .SYNC_STAGES       (SYNC_STAGES),
        .DEBOUNCE_DEPTH    (DEB_DEPTH),
        .DEBOUNCE_RATE     (DEB_RATE)
    ) dut_i (
        .cfgmclk_int       (cfgmclk_int),
        .gt_tx_reset       (gt_tx_reset),
        .reset_btn_n       (reset_btn_n),
        .sw                (sw),
        .uart_txd          (uart_txd),
        .qsfp_refclk_reset (qsfp_refclk_reset),
        .sys_reset         (sys_reset),
        .sw_debounced      (sw_debounced),
        .uart_txd_sync     (uart_txd_sync)
    );

    `include "board_mgmt_tb_tasks.svh"

    initial begin
        cfgmclk_int = 1'b0;
        forever #CLK_HALF cfgmclk_int = ~cfgmclk_int;
    end

    always @(posedge cfgmclk_int) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'heefe));
        gt_tx_reset = 1'b1;
        reset_btn_n = 1'b1;
        sw          = '0;
        uart_txd    = 1'b1;

        test_reset_state();
        test_sequence();
        test_button_restart();
        test_debounce_accept();
        test_glitch_reject();
        test_uart_sync();

        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
board_pkg.sv
signal_sync.sv
switch_debounce.sv
reset_sequencer.sv
board_mgmt_top.sv
board_mgmt_tb.sv

// File: Makefile
# Verilator build and run for the board management bring-up logic
# make          build and run the testbench
# make lint     lint the RTL
# make clean    remove build output and log

VERILATOR   ?= verilator
TOP         ?= board_mgmt_tb
RTL_TOP     ?= board_mgmt_top
FILE_LIST   ?= vlog.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= -Wall

RTL_SRCS := board_pkg.sv signal_sync.sv switch_debounce.sv \
            reset_sequencer.sv board_mgmt_top.sv
TB_SRCS  := board_mgmt_tb.sv board_mgmt_tb_tasks.svh

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(RTL_SRCS) $(TB_SRCS) $(FILE_LIST)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
